// File: hw/dbg_console_pkg.sv
package dbg_console_pkg;

    // ------------------------------------------------------------------
    // uart and reset timing
    // ------------------------------------------------------------------
    localparam int CLKS_PER_BIT = 16;           // clk cycles per serial bit
    localparam int BIT_CNT_W    = 4;            // fits 0 .. CLKS_PER_BIT-1
    localparam int RESET_HOLD   = 16;           // cpu reset low time for "r"

    // ------------------------------------------------------------------
    // cpu clock divider and select
    // ------------------------------------------------------------------
    localparam int DIV_W    = 8;
    localparam int RUN_TAP  = 3;                // half period 8 cycles
    localparam int FAST_TAP = 0;                // half period 1 cycle

    typedef enum logic [1:0] {
        CLK_SEL_MAN  = 2'd0,
        CLK_SEL_RUN  = 2'd1,
        CLK_SEL_FAST = 2'd2
    } clk_sel_t;

    // ------------------------------------------------------------------
    // console commands, ascii
    // ------------------------------------------------------------------
    localparam logic [7:0] CMD_RESET      = 8'h72;  // r
    localparam logic [7:0] CMD_RST_TOGGLE = 8'h65;  // e
    localparam logic [7:0] CMD_CLK_RISE   = 8'h7A;  // z
    localparam logic [7:0] CMD_CLK_FALL   = 8'h78;  // x
    localparam logic [7:0] CMD_CLK_PULSE  = 8'h63;  // c
    localparam logic [7:0] CMD_SEL_MAN    = 8'h6A;  // j
    localparam logic [7:0] CMD_SEL_RUN    = 8'h6B;  // k
    localparam logic [7:0] CMD_SEL_FAST   = 8'h6C;  // l

    localparam int REPLY_LEN = 4;               // two letters, cr, lf

    function automatic logic [7:0] reply_first(input logic [7:0] cmd);
        case (cmd)
            CMD_RESET, CMD_RST_TOGGLE:                 return 8'h52;  // R
            CMD_CLK_RISE, CMD_CLK_FALL, CMD_CLK_PULSE: return 8'h43;  // C
            CMD_SEL_MAN, CMD_SEL_RUN:                  return 8'h4B;  // K
            default:                                   return 8'h4F;  // O
        endcase
    endfunction

    function automatic logic [7:0] reply_second(input logic [7:0] cmd);
        case (cmd)
            CMD_RESET:      return 8'h73;  // s
            CMD_RST_TOGGLE: return 8'h61;  // a
            CMD_CLK_RISE:   return 8'h72;  // r
            CMD_CLK_FALL:   return 8'h66;  // f
            CMD_CLK_PULSE:  return 8'h74;  // t
            default:        return 8'h6B;  // k
        endcase
    endfunction

endpackage

// File: hw/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic [7:0] rx_byte_o,
    output logic       rx_done_o
);

    localparam int CNT_W = dbg_console_pkg::BIT_CNT_W;
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(dbg_console_pkg::CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(dbg_console_pkg::CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic             rx_meta;
    logic             rx_sync;
    logic [7:0]       shift;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= RX_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            rx_meta   <= 1'b1;           // idle line is high
            rx_sync   <= 1'b1;
            rx_done_o <= 1'b0;
        end else begin
            rx_meta   <= rx_i;
            rx_sync   <= rx_meta;
            rx_done_o <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: begin
                    if (cnt == CNT_HALF) begin   // middle of start bit
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch goes back
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == CNT_FULL) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin               // stop bit
                    if (cnt == CNT_FULL) begin
                        rx_done_o <= rx_sync;    // framing error is dropped
                        state     <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // data bits come in lsb first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == CNT_FULL) shift <= {rx_sync, shift[7:1]};
    end

    assign rx_byte_o = shift;

endmodule

// File: hw/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       tx_start_i,
    input  logic [7:0] tx_byte_i,
    output logic       tx_o,
    output logic       tx_done_o
);

    localparam int CNT_W = dbg_console_pkg::BIT_CNT_W;
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(dbg_console_pkg::CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (tx_start_i) begin
                        tx_o  <= 1'b0;       // start bit
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (cnt == CNT_FULL) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        tx_o    <= shift[0];
                        state   <= TX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (cnt == CNT_FULL) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            tx_o  <= 1'b1;   // stop bit
                            state <= TX_STOP;
                        end else begin
                            tx_o <= shift[0];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == CNT_FULL) state <= TX_IDLE;
                    else cnt <= cnt + 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start_i) begin
            shift <= tx_byte_i;
        end else if ((state == TX_START || state == TX_DATA) && cnt == CNT_FULL) begin
            shift <= {1'b0, shift[7:1]};     // next bit into lsb
        end
    end

    assign tx_done_o = (state == TX_STOP) && (cnt == CNT_FULL);  // last stop cycle

endmodule

// File: hw/cpu_clk_gen.sv
`timescale 1ns/10ps

module cpu_clk_gen (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      man_clk_i,
    input  dbg_console_pkg::clk_sel_t clk_sel_i,
    output logic                      cpu_clk_o
);

    logic [dbg_console_pkg::DIV_W-1:0] div_cnt;

    // free running, bit n has a half period of 2^n clk cycles
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_comb begin
        case (clk_sel_i)
            dbg_console_pkg::CLK_SEL_RUN:  cpu_clk_o = div_cnt[dbg_console_pkg::RUN_TAP];
            dbg_console_pkg::CLK_SEL_FAST: cpu_clk_o = div_cnt[dbg_console_pkg::FAST_TAP];
            default:                       cpu_clk_o = man_clk_i;  // manual stepping
        endcase
    end

endmodule

// File: hw/dbg_cmd_ctrl.sv
`timescale 1ns/10ps

module dbg_cmd_ctrl (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [7:0]                rx_byte_i,
    input  logic                      rx_done_i,
    input  logic                      tx_done_i,
    output logic                      tx_start_o,
    output logic [7:0]                tx_byte_o,
    output logic                      man_clk_o,
    output dbg_console_pkg::clk_sel_t clk_sel_o,
    output logic                      cpu_rst_n_o
);

    localparam int HOLD_W = $clog2(dbg_console_pkg::RESET_HOLD);
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(dbg_console_pkg::RESET_HOLD - 1);
    localparam logic [1:0] BYTE_LAST = 2'(dbg_console_pkg::REPLY_LEN - 1);

    typedef enum logic [3:0] {
        ST_BOOT, ST_IDLE, ST_RST_ASSERT, ST_RST_HOLD, ST_RST_TOGGLE,
        ST_CLK_RISE, ST_CLK_FALL, ST_CLK_PULSE, ST_CLK_SEL, ST_SEND, ST_WAIT
    } ctrl_state_t;

    ctrl_state_t       state;
    logic [7:0]        cmd;
    logic [HOLD_W-1:0] hold_cnt;
    logic [1:0]        byte_cnt;

    // ------------------------------------------------------------------
    // command fsm
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= ST_BOOT;
            hold_cnt    <= '0;
            byte_cnt    <= '0;
            tx_start_o  <= 1'b0;
            man_clk_o   <= 1'b0;
            clk_sel_o   <= dbg_console_pkg::CLK_SEL_MAN;
            cpu_rst_n_o <= 1'b0;             // cpu held until the board is up
        end else begin
            tx_start_o <= 1'b0;
            case (state)
                ST_BOOT: begin
                    cpu_rst_n_o <= 1'b1;
                    state       <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (rx_done_i) begin
                        case (rx_byte_i)
                            dbg_console_pkg::CMD_RESET:      state <= ST_RST_ASSERT;
                            dbg_console_pkg::CMD_RST_TOGGLE: state <= ST_RST_TOGGLE;
                            dbg_console_pkg::CMD_CLK_RISE:   state <= ST_CLK_RISE;
                            dbg_console_pkg::CMD_CLK_FALL:   state <= ST_CLK_FALL;
                            dbg_console_pkg::CMD_CLK_PULSE:  state <= ST_CLK_PULSE;
                            dbg_console_pkg::CMD_SEL_MAN,
                            dbg_console_pkg::CMD_SEL_RUN,
                            dbg_console_pkg::CMD_SEL_FAST:   state <= ST_CLK_SEL;
                            default:                         state <= ST_SEND;  // just "Ok"
                        endcase
                    end
                end
                ST_RST_ASSERT: begin
                    cpu_rst_n_o <= 1'b0;
                    hold_cnt    <= '0;
                    man_clk_o   <= ~man_clk_o;   // cpu sees edges while in reset
                    state       <= ST_RST_HOLD;
                end
                ST_RST_HOLD: begin
                    man_clk_o <= ~man_clk_o;
                    hold_cnt  <= hold_cnt + 1'b1;
                    if (hold_cnt == HOLD_LAST) begin
                        cpu_rst_n_o <= 1'b1;
                        state       <= ST_SEND;
                    end
                end
                ST_RST_TOGGLE: begin
                    cpu_rst_n_o <= ~cpu_rst_n_o;
                    state       <= ST_SEND;
                end
                ST_CLK_RISE: begin
                    man_clk_o <= 1'b1;
                    state     <= ST_SEND;
                end
                ST_CLK_FALL: begin
                    man_clk_o <= 1'b0;
                    state     <= ST_SEND;
                end
                ST_CLK_PULSE: begin
                    man_clk_o <= 1'b1;
                    state     <= ST_CLK_FALL;    // high for one cycle only
                end
                ST_CLK_SEL: begin
                    case (cmd)
                        dbg_console_pkg::CMD_SEL_RUN:  clk_sel_o <= dbg_console_pkg::CLK_SEL_RUN;
                        dbg_console_pkg::CMD_SEL_FAST: clk_sel_o <= dbg_console_pkg::CLK_SEL_FAST;
                        default:                       clk_sel_o <= dbg_console_pkg::CLK_SEL_MAN;
                    endcase
                    state <= ST_SEND;
                end
                // ----------------------------------------------------------
                // reply, one byte per tx frame
                // ----------------------------------------------------------
                ST_SEND: begin
                    tx_start_o <= 1'b1;
                    state      <= ST_WAIT;
                end
                default: begin
                    if (tx_done_i) begin
                        byte_cnt <= byte_cnt + 1'b1;  // wraps to 0 after lf
                        state    <= (byte_cnt == BYTE_LAST) ? ST_IDLE : ST_SEND;
                    end
                end
            endcase
        end
    end

    // command byte and reply byte
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && rx_done_i) cmd <= rx_byte_i;
        if (state == ST_SEND) begin
            case (byte_cnt)
                2'd0:    tx_byte_o <= dbg_console_pkg::reply_first(cmd);
                2'd1:    tx_byte_o <= dbg_console_pkg::reply_second(cmd);
                2'd2:    tx_byte_o <= 8'h0D;     // cr
                default: tx_byte_o <= 8'h0A;     // lf
            endcase
        end
    end

endmodule

// File: hw/dbg_console_top.sv
`timescale 1ns/10ps

module dbg_console_top (
    input  logic clk,
    input  logic rst_n_i,
    input  logic rx_i,
    output logic tx_o,
    output logic cpu_clk_o,
    output logic cpu_rst_n_o
);

    logic [7:0]                rx_byte;
    logic                      rx_done;
    logic                      tx_start;
    logic [7:0]                tx_byte;
    logic                      tx_done;
    logic                      man_clk;
    dbg_console_pkg::clk_sel_t clk_sel;

    // ------------------------------------------------------------------
    // serial side
    // ------------------------------------------------------------------
    uart_rx u_uart_rx (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rx_i      (rx_i),
        .rx_byte_o (rx_byte),
        .rx_done_o (rx_done)
    );

    uart_tx u_uart_tx (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .tx_start_i (tx_start),
        .tx_byte_i  (tx_byte),
        .tx_o       (tx_o),
        .tx_done_o  (tx_done)
    );

    // ------------------------------------------------------------------
    // command control and cpu clock
    // ------------------------------------------------------------------
    dbg_cmd_ctrl u_dbg_cmd_ctrl (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_byte_i   (rx_byte),
        .rx_done_i   (rx_done),
        .tx_done_i   (tx_done),
        .tx_start_o  (tx_start),
        .tx_byte_o   (tx_byte),
        .man_clk_o   (man_clk),
        .clk_sel_o   (clk_sel),
        .cpu_rst_n_o (cpu_rst_n_o)
    );

    cpu_clk_gen u_cpu_clk_gen (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .man_clk_i (man_clk),
        .clk_sel_i (clk_sel),
        .cpu_clk_o (cpu_clk_o)
    );

endmodule

// File: sim/dbg_console_asserts.sv
`timescale 1ns/10ps

module dbg_console_asserts (
    input logic       clk,
    input logic       rst_n_i,
    input logic       rx_done_i,
    input logic [7:0] rx_byte_i,
    input logic       tx_start_i,
    input logic       tx_done_i,
    input logic       cpu_rst_n_i
);

    logic       tx_busy;                               // frame in flight
    logic       reply_busy;                            // first start to fourth done
    logic [1:0] frame_cnt;
    logic       rst_cmd;                               // last command was "r"

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_busy    <= 1'b0;
            reply_busy <= 1'b0;
            frame_cnt  <= '0;
            rst_cmd    <= 1'b0;
        end else begin
            if (tx_start_i) tx_busy <= 1'b1;
            else if (tx_done_i) tx_busy <= 1'b0;
            if (tx_start_i) reply_busy <= 1'b1;
            if (tx_done_i) begin
                frame_cnt <= frame_cnt + 1'b1;
                if (frame_cnt == 2'd3) reply_busy <= 1'b0;
            end
            if (rx_done_i && !reply_busy) rst_cmd <= (rx_byte_i == dbg_console_pkg::CMD_RESET);
        end
    end

    start_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_start_i |=> !tx_start_i) else $error("tx_start_o held longer than one cycle");

    no_restart: assert property (@(posedge clk) disable iff (!rst_n_i)
        tx_busy |-> !tx_start_i) else $error("tx_start_o raised before tx_done_i");

    rst_steady: assert property (@(posedge clk) disable iff (!rst_n_i)
        reply_busy |-> $stable(cpu_rst_n_i)) else $error("cpu_rst_n_o changed during a reply");

    rst_released: assert property (@(posedge clk) disable iff (!rst_n_i)
        (reply_busy && rst_cmd) |-> cpu_rst_n_i) else $error("cpu reset still low in reply");

endmodule

bind dbg_cmd_ctrl dbg_console_asserts u_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rx_done_i   (rx_done_i),
    .rx_byte_i   (rx_byte_i),
    .tx_start_i  (tx_start_o),
    .tx_done_i   (tx_done_i),
    .cpu_rst_n_i (cpu_rst_n_o)
);

// File: sim/tb_dbg_console.sv
`timescale 1ns/10ps

module tb_dbg_console;

    localparam int CLKS_PER_BIT  = 16;                  // serial bit time of the console
    localparam int START_TIMEOUT = 40 * CLKS_PER_BIT;   // cycles to wait for a start bit
    localparam int CMD_TIMEOUT   = 120 * CLKS_PER_BIT;  // command frame plus four replies
    localparam int EDGE_TIMEOUT  = 64;

    logic       clk;
    logic       rst_n_i;
    logic       rx_i;
    logic       tx_o;
    logic       cpu_clk_o;
    logic       cpu_rst_n_o;
    int         errors;
    int         checks;
    int         timeouts;
    logic       reply_done;
    int         rise_cnt;
    int         low_cnt;
    logic [7:0] reply_bytes [4];

    dbg_console_top dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .rx_i        (rx_i),
        .tx_o        (tx_o),
        .cpu_clk_o   (cpu_clk_o),
        .cpu_rst_n_o (cpu_rst_n_o)
    );

    always #4 clk = ~clk;                               // 8 ns period

    // ----------------------------------------------------------------------
    // check and report helpers
    // ----------------------------------------------------------------------
    task automatic report_timeout(input string why);
        timeouts++;
        $display("%s", why);
    endtask

    task automatic compare_value(input string name, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t ns %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t ns %s expected 8'h%h got 8'h%h", $time, name, exp, got);
        end
    endtask

    // ----------------------------------------------------------------------
    // serial line driver and decoder
    // ----------------------------------------------------------------------
    task automatic send_command(input logic [7:0] data);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, data, 1'b0};                     // stop, data lsb first, start
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_i <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic read_reply_byte(input int idx, output logic [7:0] data);
        int waited;
        int i;
        data   = '0;
        waited = 0;
        while (tx_o !== 1'b0 && waited < START_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= START_TIMEOUT) begin
            report_timeout($sformatf("timeout waiting for the start bit of reply byte %0d", idx));
        end else begin
            repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);  // middle of start bit
            compare_value("tx_o start bit", 0, int'(tx_o));
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[i] = tx_o;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            compare_value("tx_o stop bit", 1, int'(tx_o));
        end
    endtask

    // counts cpu clock rises and cpu reset low cycles until the reply is in
    task automatic watch_command();
        int   waited;
        logic last_clk;
        rise_cnt = 0;
        low_cnt  = 0;
        waited   = 0;
        last_clk = cpu_clk_o;
        while (!reply_done && waited < CMD_TIMEOUT) begin
            @(negedge clk);
            waited++;
            if (cpu_clk_o && !last_clk) rise_cnt++;
            if (!cpu_rst_n_o) low_cnt++;
            last_clk = cpu_clk_o;
        end
        if (!reply_done) report_timeout("timeout while a command and its reply were running");
    endtask

    task automatic check_half_period(input int exp_half);
        int   waited;
        int   cycles;
        logic lvl;
        cycles = 0;
        waited = 0;
        lvl    = cpu_clk_o;
        while (cpu_clk_o === lvl && waited < EDGE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= EDGE_TIMEOUT) begin
            report_timeout("timeout waiting for cpu_clk_o to toggle");
        end else begin
            lvl = cpu_clk_o;
            while (cpu_clk_o === lvl && cycles < EDGE_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (cycles >= EDGE_TIMEOUT) begin
                report_timeout("cpu_clk_o stopped toggling");
            end else begin
                compare_value("cpu_clk_o half period", exp_half, cycles);
            end
        end
    endtask

    task automatic run_command(input logic [7:0] cmd, input logic [31:0] exp_reply,
                               input int exp_clk, input int exp_rst, input int exp_half,
                               input int exp_rises, input int exp_lows);
        int k;
        reply_done = 1'b0;
        fork
            send_command(cmd);
            begin
                int j;
                for (j = 0; j < 4 && timeouts == 0; j++) read_reply_byte(j, reply_bytes[j]);
                if (timeouts == 0) begin
                    repeat (CLKS_PER_BIT / 2 + 2) @(negedge clk);  // rest of last stop bit
                end
                reply_done = 1'b1;
            end
            watch_command();
        join
        if (timeouts == 0) begin
            for (k = 0; k < 4; k++) begin
                compare_byte($sformatf("tx_o reply byte %0d to 8'h%h", k, cmd),
                             exp_reply[31 - 8 * k -: 8], reply_bytes[k]);
            end
            if (exp_clk != 2) compare_value("cpu_clk_o", exp_clk, int'(cpu_clk_o));
            compare_value("cpu_rst_n_o", exp_rst, int'(cpu_rst_n_o));
            if (exp_rises != 0) compare_value("cpu_clk_o rising edges", exp_rises, rise_cnt);
            if (exp_lows != 0) compare_value("cpu_rst_n_o low cycles", exp_lows, low_cnt);
            if (exp_half != 0) check_half_period(exp_half);
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        int    fd;
        int    n;
        int    cmd_count;
        int    cmd, b0, b1, b2, b3;
        int    lvl_clk, lvl_rst, half, rises, lows;
        string line;
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        rx_i       = 1'b1;                              // idle line
        errors     = 0;
        checks     = 0;
        timeouts   = 0;
        reply_done = 1'b0;
        cmd_count  = 0;
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (4) @(negedge clk);
        compare_value("tx_o", 1, int'(tx_o));
        compare_value("cpu_rst_n_o", 1, int'(cpu_rst_n_o));
        fd = $fopen("sim/dbg_console_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/dbg_console_stimulus.txt");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                n = $fgets(line, fd);
                if (n != 0) begin
                    n = $sscanf(line, "%h %h %h %h %h %d %d %d %d %d", cmd, b0, b1, b2, b3,
                                lvl_clk, lvl_rst, half, rises, lows);
                    if (n == 10) begin                  // comment lines do not parse
                        run_command(cmd[7:0], {b0[7:0], b1[7:0], b2[7:0], b3[7:0]},
                                    lvl_clk, lvl_rst, half, rises, lows);
                        cmd_count++;
                    end
                end
            end
            $fclose(fd);
        end
        assert (cmd_count > 0) else begin
            errors++;
            $display("no command lines were found in the stimulus file");
        end
        $display("summary: %0d commands, %0d checks, %0d errors, %0d timeouts",
                 cmd_count, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: sim/dbg_console_stimulus.txt
# cmd b0 b1 b2 b3 (hex), then cpu_clk_o, cpu_rst_n_o after the reply, half period, rises, lows
# cpu_clk_o 2 means no check; half period, rises and lows 0 mean no check
71 4f 6b 0d 0a 0 1 0 0 0
7a 43 72 0d 0a 1 1 0 1 0
78 43 66 0d 0a 0 1 0 0 0
63 43 74 0d 0a 0 1 0 1 0
65 52 61 0d 0a 0 0 0 0 0
65 52 61 0d 0a 0 1 0 0 0
72 52 73 0d 0a 2 1 0 0 16
6b 4b 6b 0d 0a 2 1 8 0 0
6c 4f 6b 0d 0a 2 1 1 0 0
6a 4b 6b 0d 0a 2 1 0 0 0
78 43 66 0d 0a 0 1 0 0 0
7a 43 72 0d 0a 1 1 0 1 0

// File: dbg_console_top.f
hw/dbg_console_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/cpu_clk_gen.sv
hw/dbg_cmd_ctrl.sv
hw/dbg_console_top.sv
sim/dbg_console_asserts.sv
sim/tb_dbg_console.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_dbg_console -f dbg_console_top.f || { echo "build failed"; exit 1; }
./obj_dir/Vtb_dbg_console > sim.log 2>&1
cat sim.log
grep -q "all tests passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
